// ==== peak_pkg.sv ====
/*
  Stream-side definitions for the peak tagging front end.
  Holds the channel layout, the sample and tag types, and the
  128-bit frame word that is read either as samples or as a tag.
  Modules take it with a wildcard import in their header.
*/

package peak_pkg;

  ////////////////////
  // stream geometry
  ////////////////////

  // four unsigned channels per beat
  localparam int NUM_CHANNELS = 4;
  localparam int CHANNEL_WIDTH = 32;

  // one beat, also the FIFO write width
  localparam int DATA_WIDTH = NUM_CHANNELS * CHANNEL_WIDTH;

  // tag layout
  localparam int NUM_TAGS = 10;
  localparam int INDEX_WIDTH = NUM_TAGS - NUM_CHANNELS;

  ////////////////////
  // types
  ////////////////////

  // one channel sample, unsigned
  typedef logic [CHANNEL_WIDTH-1:0] sample_t;

  // per-frame tag
  // bits 3:0 hit flags, bits 9:4 beat index of the channel 0 peak
  typedef struct packed {
    logic [INDEX_WIDTH-1:0]  peak_index;
    logic [NUM_CHANNELS-1:0] hit_flags;
  } tag_t;

  // FIFO write word, decoded two ways
  // samples view: channel 0 sits in the low bits
  // tag view: zero pad above the tag
  typedef union packed {
    sample_t [NUM_CHANNELS-1:0] samples;
    struct packed {
      logic [DATA_WIDTH-NUM_TAGS-1:0] pad;
      tag_t                           tag;
    } tag;
  } frame_word_u;

endpackage

// ==== host_pkg.sv ====
/*
  Host-side definitions for the strobed read port.
  The microprocessor bus is 16 bits wide; narrower FIFO reads
  are zero-extended to this width.
*/

package host_pkg;

  // host data bus
  localparam int HOST_WIDTH = 16;

  // one word as seen by the processor
  typedef logic [HOST_WIDTH-1:0] host_word_t;

endpackage

// ==== peak_tagger.sv ====
/*
  Cuts the four-channel sample stream into frames of FRAME_LEN beats
  and builds a tag per frame: one above-threshold flag per channel and
  the beat index of the largest channel 0 sample (earliest on ties).
  One output register stage; the tag is valid on the tlast beat.
*/

module peak_tagger
  import peak_pkg::*;
#(
  parameter int FRAME_LEN = 8
) (
  input  logic        clk,
  input  logic        rst_n,

  // threshold level, compared strictly greater
  input  sample_t     thresh,

  // input stream
  input  logic        s_tvalid,
  output logic        s_tready,
  input  frame_word_u s_tdata,

  // tagged output stream
  output logic        t_tvalid,
  input  logic        t_tready,
  output frame_word_u t_tdata,
  output tag_t        t_tuser,
  output logic        t_tlast
);

  // beat counter, same width as the tag index field
  logic [INDEX_WIDTH-1:0]  beat_cnt;
  logic                    last_beat;
  logic                    s_beat;

  // per-beat comparisons
  logic [NUM_CHANNELS-1:0] over_thresh;
  logic                    new_max;

  // running frame state
  tag_t                    run_tag;
  sample_t                 run_max;

  // state including the current beat
  tag_t                    cur_tag;
  sample_t                 cur_max;

  ////////////////////
  // handshake
  ////////////////////

  // accept when the output slot is empty or being drained
  assign s_tready = ~t_tvalid | t_tready;
  assign s_beat = s_tvalid & s_tready;

  assign last_beat = (beat_cnt == INDEX_WIDTH'(FRAME_LEN - 1));

  ////////////////////
  // tag arithmetic
  ////////////////////

  always_comb begin
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      over_thresh[ch] = (s_tdata.samples[ch] > thresh);
    end
  end

  // strictly greater keeps the earliest beat on ties
  // cleared state (max 0, index 0) covers beat 0 as well
  assign new_max = (s_tdata.samples[0] > run_max);

  always_comb begin
    cur_tag.hit_flags = run_tag.hit_flags | over_thresh;
    cur_tag.peak_index = new_max ? beat_cnt : run_tag.peak_index;
    cur_max = new_max ? s_tdata.samples[0] : run_max;
  end

  // counter and running state advance on accepted beats only
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      run_tag <= '0;
      run_max <= '0;
    end else if (s_beat) begin
      if (last_beat) begin
        // frame done, start clean
        beat_cnt <= '0;
        run_tag <= '0;
        run_max <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
        run_tag <= cur_tag;
        run_max <= cur_max;
      end
    end
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      t_tvalid <= 1'b0;
    end else if (s_tready) begin
      t_tvalid <= s_tvalid;
    end
  end

  // payload, qualified by t_tvalid
  always_ff @(posedge clk) begin
    if (s_beat) begin
      t_tdata <= s_tdata;
      t_tuser <= cur_tag;
      t_tlast <= last_beat;
    end
  end

endmodule

// ==== sync_fifo_w2n.sv ====
/*
  Single-clock FIFO, wide write and narrow read.
  Each write stores one DATA_WIDTH word; each read returns one
  READ_WIDTH piece, least significant piece first, one cycle later.
  full and empty are tracked in whole words.
*/

module sync_fifo_w2n
  import peak_pkg::*;
#(
  parameter int FIFO_DEPTH = 16,
  parameter int READ_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,

  // write side
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] din,
  output logic                  full,

  // read side
  input  logic                  rd_en,
  output logic [READ_WIDTH-1:0] dout,
  output logic                  empty
);

  // pieces per word and pointer widths
  localparam int PIECES = DATA_WIDTH / READ_WIDTH;
  localparam int PIECE_W = $clog2(PIECES);
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // word storage
  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // write pointer in words, one wrap bit on top
  logic [ADDR_W:0]         wr_ptr;

  // read pointer in pieces, low bits pick the piece
  logic [ADDR_W+PIECE_W:0] rd_ptr;

  logic [ADDR_W:0]         rd_word;
  logic [PIECE_W-1:0]      rd_piece;
  logic [DATA_WIDTH-1:0]   rd_line;

  logic                    do_write;
  logic                    do_read;

  ////////////////////
  // pointers, flags
  ////////////////////

  assign rd_word = rd_ptr[ADDR_W+PIECE_W:PIECE_W];
  assign rd_piece = rd_ptr[PIECE_W-1:0];

  // a word leaves only after its last piece is read
  assign empty = (wr_ptr == rd_word);
  assign full = (wr_ptr[ADDR_W] != rd_word[ADDR_W]) &&
                (wr_ptr[ADDR_W-1:0] == rd_word[ADDR_W-1:0]);

  // overflow and underflow requests are dropped
  assign do_write = wr_en & ~full;
  assign do_read = rd_en & ~empty;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////
  // storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[ADDR_W-1:0]] <= din;
    end
  end

  assign rd_line = mem[rd_word[ADDR_W-1:0]];

  // registered piece, held until the next pop
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (do_read) begin
      dout <= rd_line[rd_piece*READ_WIDTH +: READ_WIDTH];
    end
  end

endmodule

// ==== buf_peak_data.sv ====
/*
  Buffers tagged frames for a small microprocessor.
  Every accepted beat goes into the FIFO, followed by one zero-padded
  tag word after the frame's last beat. The host pops one piece per
  rising edge of rd_ena and sees it on rd_data the cycle after.
*/

module buf_peak_data
  import peak_pkg::*;
  import host_pkg::*;
#(
  parameter int FIFO_DEPTH = 16,
  parameter int READ_WIDTH = 16
) (
  input  logic        clk,
  input  logic        rst_n,

  // tagged stream in
  input  logic        t_tvalid,
  output logic        t_tready,
  input  frame_word_u t_tdata,
  input  tag_t        t_tuser,
  input  logic        t_tlast,

  // processor read port
  input  logic        rd_ena,
  output logic        rd_ready,
  output host_word_t  rd_data
);

  logic                  rd_ena_d;
  logic                  aux_valid;
  tag_t                  aux_tag;
  frame_word_u           aux_word;

  logic                  t_beat;
  logic                  aux_frame;

  logic                  fifo_full;
  logic                  fifo_empty;
  logic [READ_WIDTH-1:0] fifo_dout;

  ////////////////////
  // write side
  ////////////////////

  // stall the stream while the tag word is pending or no room
  assign t_tready = ~aux_valid & ~fifo_full;
  assign t_beat = t_tvalid & t_tready;

  // tag word goes in once there is space
  assign aux_frame = aux_valid & ~fifo_full;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      aux_valid <= 1'b0;
    end else if (aux_frame) begin
      aux_valid <= 1'b0;
    end else if (t_beat && t_tlast) begin
      aux_valid <= 1'b1;
    end
  end

  // t_tuser moves on after tlast, keep a copy
  always_ff @(posedge clk) begin
    if (t_beat && t_tlast) begin
      aux_tag <= t_tuser;
    end
  end

  always_comb begin
    aux_word.tag.pad = '0;
    aux_word.tag.tag = aux_tag;
  end

  ////////////////////
  // FIFO
  ////////////////////

  sync_fifo_w2n #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .READ_WIDTH (READ_WIDTH)
  ) i_sync_fifo_w2n (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (aux_frame | t_beat),
    .din   (aux_valid ? aux_word : t_tdata),
    .full  (fifo_full),
    .rd_en (rd_ena & ~rd_ena_d),
    .dout  (fifo_dout),
    .empty (fifo_empty)
  );

  ////////////////////
  // read side
  ////////////////////

  // previous strobe level for edge detect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ena_d <= 1'b0;
    end else begin
      rd_ena_d <= rd_ena;
    end
  end

  // upper bits zero for 8-bit reads
  assign rd_data = HOST_WIDTH'(fifo_dout);
  assign rd_ready = ~fifo_empty;

endmodule

// ==== peak_detect_top.sv ====
/*
  Top of the peak tagging front end.
  Sample stream goes through the tagger into the frame buffer,
  which the processor drains through the strobed read port.
  Frame length, buffer depth and read width are set here.
*/

module peak_detect_top
  import peak_pkg::*;
  import host_pkg::*;
#(
  parameter int FRAME_LEN = 8,
  parameter int FIFO_DEPTH = 16,
  parameter int READ_WIDTH = 16
) (
  input  logic        clk,
  input  logic        rst_n,

  // threshold level
  input  sample_t     thresh,

  // sample stream in
  input  logic        s_tvalid,
  output logic        s_tready,
  input  frame_word_u s_tdata,

  // processor read port
  input  logic        rd_ena,
  output logic        rd_ready,
  output host_word_t  rd_data
);

  // tagger to buffer
  logic        t_tvalid;
  logic        t_tready;
  frame_word_u t_tdata;
  tag_t        t_tuser;
  logic        t_tlast;

  ////////////////////
  // frame tagging
  ////////////////////

  peak_tagger #(
    .FRAME_LEN (FRAME_LEN)
  ) i_peak_tagger (
    .clk      (clk),
    .rst_n    (rst_n),
    .thresh   (thresh),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .t_tvalid (t_tvalid),
    .t_tready (t_tready),
    .t_tdata  (t_tdata),
    .t_tuser  (t_tuser),
    .t_tlast  (t_tlast)
  );

  ////////////////////
  // buffer, host port
  ////////////////////

  buf_peak_data #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .READ_WIDTH (READ_WIDTH)
  ) i_buf_peak_data (
    .clk      (clk),
    .rst_n    (rst_n),
    .t_tvalid (t_tvalid),
    .t_tready (t_tready),
    .t_tdata  (t_tdata),
    .t_tuser  (t_tuser),
    .t_tlast  (t_tlast),
    .rd_ena   (rd_ena),
    .rd_ready (rd_ready),
    .rd_data  (rd_data)
  );

endmodule

// ==== tb_clk_gen.sv ====
/*
  Testbench clock and power-on reset.
  rst_n stays low over the first RESET_CYCLES rising edges and is
  released a short delay after the last of them.
*/

module tb_clk_gen #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 3,
  parameter int RELEASE_DLY = 5
) (
  output logic clk,
  output logic rst_n
);

  // free running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // power-on reset
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #RELEASE_DLY;
    rst_n = 1'b1;
  end

endmodule

// ==== tb_peak_detect.sv ====
/*
  Testbench for the peak tagging front end.
  Random frames go in on the sample stream, a host reader drains the
  buffer through the strobed port, and every piece is compared with a
  queue model built from the tag rules. Inputs change 5 units after clk.
*/

module tb_peak_detect
  import peak_pkg::*;
  import host_pkg::*;
();

  localparam int FRAME_LEN = 8;
  localparam int PIECES = DATA_WIDTH / HOST_WIDTH;
  localparam int FRAME_PIECES = (FRAME_LEN + 1) * PIECES;
  localparam int DRIVE_DLY = 5;
  localparam int WAIT_LIMIT = 2000;
  localparam int STALL_RUN = 10;
  localparam int SEED = 9;

  // how frame samples are made
  localparam int MODE_RANDOM = 0;
  localparam int MODE_SMALL = 1;
  localparam int MODE_TIE = 2;
  localparam int MODE_FLAT = 3;
  localparam int MODE_FULL = 4;

  logic        clk;
  logic        por_n;
  logic        soft_rst_n;
  logic        rst_n;
  sample_t     thresh;
  logic        s_tvalid;
  logic        s_tready;
  frame_word_u s_tdata;
  logic        rd_ena;
  logic        rd_ready;
  host_word_t  rd_data;

  // model state in host read order
  host_word_t  exp_q[$];
  bit          tag_first_q[$];
  tag_t        exp_tag_q[$];
  frame_word_u cur_beats [FRAME_LEN];

  // last piece the model handed out
  host_word_t  last_exp;

  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  int          tests_run;
  bit          timed_out;

  // power-on reset or a reset forced by a test
  assign rst_n = por_n & soft_rst_n;

  tb_clk_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (3),
    .RELEASE_DLY  (DRIVE_DLY)
  ) i_tb_clk_gen (
    .clk   (clk),
    .rst_n (por_n)
  );

  peak_detect_top i_peak_detect_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .thresh   (thresh),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tdata  (s_tdata),
    .rd_ena   (rd_ena),
    .rd_ready (rd_ready),
    .rd_data  (rd_data)
  );

  ////////////////////
  // timing and checks
  ////////////////////

  // every drive and sample point sits just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s, gave up after %0d cycles", what, WAIT_LIMIT);
    errors++;
    timed_out = 1'b1;
  endtask

  task automatic check_sample_piece(input string name, input host_word_t got,
                                    input host_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_tag(input tag_t got, input tag_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED rd_data tag: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////
  // model
  ////////////////////

  function automatic sample_t gen_sample(input int mode, input int beat, input int ch);
    sample_t s;
    if (mode == MODE_FULL) return '1;
    if (mode == MODE_RANDOM) return $urandom();
    if (ch == 0) begin
      case (mode)
        // equal peaks on beats 2 and 5
        MODE_TIE: s = (beat == 2 || beat == 5) ? 32'd1000 : $urandom_range(0, 999);
        MODE_FLAT: s = 32'd7;
        // tiny range gives lots of ties
        default: s = $urandom_range(0, 3);
      endcase
    end else begin
      s = ($urandom_range(0, 3) == 0) ? 32'd0 : $urandom_range(1, 255);
    end
    return s;
  endfunction

  task automatic build_frame(input int mode, input logic [NUM_CHANNELS-1:0] zero_mask);
    for (int b = 0; b < FRAME_LEN; b++) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        cur_beats[b].samples[ch] = zero_mask[ch] ? 32'd0 : gen_sample(mode, b, ch);
      end
    end
  endtask

  // a flag is set by any sample above th
  // index is the first beat holding the channel 0 max
  function automatic tag_t model_tag(input sample_t th);
    tag_t    t;
    sample_t mx;
    t = '0;
    mx = cur_beats[0].samples[0];
    for (int b = 0; b < FRAME_LEN; b++) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        if (cur_beats[b].samples[ch] > th) t.hit_flags[ch] = 1'b1;
      end
      if (b > 0 && cur_beats[b].samples[0] > mx) begin
        mx = cur_beats[b].samples[0];
        t.peak_index = INDEX_WIDTH'(b);
      end
    end
    return t;
  endfunction

  // low piece first and the tag word after the samples
  task automatic push_model(input tag_t tag);
    logic [DATA_WIDTH-1:0] raw;
    host_word_t            tag_piece;
    for (int b = 0; b < FRAME_LEN; b++) begin
      raw = cur_beats[b];
      for (int p = 0; p < PIECES; p++) begin
        exp_q.push_back(raw[p*HOST_WIDTH +: HOST_WIDTH]);
        tag_first_q.push_back(1'b0);
      end
    end
    tag_piece = '0;
    tag_piece[NUM_TAGS-1:0] = tag;
    for (int p = 0; p < PIECES; p++) begin
      exp_q.push_back((p == 0) ? tag_piece : host_word_t'(0));
      tag_first_q.push_back(p == 0);
    end
    exp_tag_q.push_back(tag);
  endtask

  task automatic clear_model();
    exp_q.delete();
    tag_first_q.delete();
    exp_tag_q.delete();
  endtask

  ////////////////////
  // stream side
  ////////////////////

  task automatic send_beat(input frame_word_u w);
    int waited;
    if (timed_out) return;
    waited = 0;
    s_tdata = w;
    s_tvalid = 1'b1;
    // ready seen now is ready at the coming edge
    while (!s_tready) begin
      if (waited >= WAIT_LIMIT) begin
        report_timeout("s_tready");
        s_tvalid = 1'b0;
        return;
      end
      next_cycle();
      waited++;
    end
    next_cycle();
    s_tvalid = 1'b0;
  endtask

  task automatic send_frame(input int mode, input logic [NUM_CHANNELS-1:0] zero_mask,
                            input sample_t th);
    tag_t tag;
    thresh = th;
    build_frame(mode, zero_mask);
    tag = model_tag(th);
    push_model(tag);
    for (int b = 0; b < FRAME_LEN; b++) begin
      idle($urandom_range(0, 2));
      send_beat(cur_beats[b]);
    end
  endtask

  ////////////////////
  // host side
  ////////////////////

  task automatic wait_rd_ready();
    int waited;
    waited = 0;
    while (!rd_ready && !timed_out) begin
      if (waited >= WAIT_LIMIT) begin
        report_timeout("rd_ready");
        return;
      end
      next_cycle();
      waited++;
    end
  endtask

  // strobe high for one edge and the piece shows one cycle later
  task automatic read_piece(output host_word_t got);
    got = '0;
    wait_rd_ready();
    if (timed_out) return;
    rd_ena = 1'b1;
    next_cycle();
    got = rd_data;
    rd_ena = 1'b0;
    next_cycle();
  endtask

  task automatic check_next_piece(input host_word_t got);
    host_word_t exp;
    tag_t       got_tag;
    if (exp_q.size() == 0) begin
      errors++;
      $display("read piece 0x%h but the model expected no more data", got);
      return;
    end
    exp = exp_q.pop_front();
    last_exp = exp;
    if (tag_first_q.pop_front()) begin
      got_tag = got[NUM_TAGS-1:0];
      check_tag(got_tag, exp_tag_q.pop_front());
    end
    check_sample_piece("rd_data", got, exp);
  endtask

  task automatic drain(input int n);
    host_word_t got;
    for (int i = 0; i < n; i++) begin
      if (timed_out) return;
      read_piece(got);
      if (!timed_out) check_next_piece(got);
      idle($urandom_range(0, 2));
    end
  endtask

  // buffer counts as full once ready stays low for a while
  task automatic wait_stall();
    int waited;
    int low_run;
    waited = 0;
    low_run = 0;
    while (low_run < STALL_RUN && !timed_out) begin
      if (waited >= WAIT_LIMIT) begin
        report_timeout("s_tready to stay low");
        return;
      end
      low_run = s_tready ? 0 : low_run + 1;
      next_cycle();
      waited++;
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1) begin
      if (waited >= WAIT_LIMIT) begin
        report_timeout("reset release");
        return;
      end
      @(posedge clk);
      waited++;
    end
    #DRIVE_DLY;
  endtask

  task automatic start_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input int num, input string name);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected pieces were never read back", exp_q.size());
      clear_model();
    end
    tests_run++;
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - test_checks, errors - test_errors);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    logic [NUM_CHANNELS-1:0] mask;
    void'($urandom(SEED));
    s_tvalid = 1'b0;
    s_tdata = '0;
    thresh = '0;
    rd_ena = 1'b0;
    soft_rst_n = 1'b1;
    last_exp = '0;
    checks = 0;
    errors = 0;
    tests_run = 0;
    timed_out = 1'b0;
    wait_reset_release();

    // test 1 reads back one frame at a time
    start_test();
    for (int f = 0; f < 3; f++) begin
      send_frame(MODE_RANDOM, '0, $urandom());
      drain(FRAME_PIECES);
    end
    end_test(1, "single frames");

    // test 2 covers both threshold ends and channel 0 ties
    start_test();
    send_frame(MODE_RANDOM, '0, '1);
    drain(FRAME_PIECES);
    send_frame(MODE_SMALL, '0, '1);
    drain(FRAME_PIECES);
    mask = NUM_CHANNELS'($urandom_range(0, 15));
    send_frame(MODE_SMALL, mask, '0);
    drain(FRAME_PIECES);
    mask = NUM_CHANNELS'($urandom_range(0, 15)) & 4'b1110;
    send_frame(MODE_TIE, mask, '0);
    drain(FRAME_PIECES);
    send_frame(MODE_FLAT, '0, '0);
    drain(FRAME_PIECES);
    end_test(2, "threshold extremes and ties");

    // test 3 checks a held strobe and strobes on an empty buffer
    start_test();
    send_frame(MODE_RANDOM, '0, $urandom());
    wait_rd_ready();
    rd_ena = 1'b1;
    next_cycle();
    check_next_piece(rd_data);
    repeat (4) begin
      next_cycle();
      check_sample_piece("rd_data", rd_data, last_exp);
    end
    rd_ena = 1'b0;
    next_cycle();
    check_sample_piece("rd_data", rd_data, last_exp);
    drain(FRAME_PIECES - 1);
    check_flag("rd_ready", rd_ready, 1'b0);
    repeat (3) begin
      rd_ena = 1'b1;
      next_cycle();
      rd_ena = 1'b0;
      next_cycle();
      check_sample_piece("rd_data", rd_data, last_exp);
      check_flag("rd_ready", rd_ready, 1'b0);
    end
    send_frame(MODE_RANDOM, '0, $urandom());
    drain(FRAME_PIECES);
    end_test(3, "read strobe");

    // test 4 fills the buffer until the stream stalls and then drains it
    start_test();
    fork
      begin
        for (int f = 0; f < 4; f++) begin
          send_frame(MODE_RANDOM, '0, $urandom());
        end
      end
      begin
        wait_stall();
        drain(4 * FRAME_PIECES);
      end
    join
    check_flag("rd_ready", rd_ready, 1'b0);
    end_test(4, "back-pressure");

    // test 5 resets in the middle of a frame
    // all-ones beats before reset would leave a visible max or flag
    start_test();
    send_frame(MODE_RANDOM, '0, $urandom());
    build_frame(MODE_FULL, '0);
    thresh = '0;
    for (int b = 0; b < 3; b++) begin
      send_beat(cur_beats[b]);
    end
    idle(2);
    soft_rst_n = 1'b0;
    idle(3);
    soft_rst_n = 1'b1;
    clear_model();
    next_cycle();
    check_flag("rd_ready", rd_ready, 1'b0);
    check_flag("s_tready", s_tready, 1'b1);
    check_sample_piece("rd_data", rd_data, '0);
    send_frame(MODE_SMALL, '0, 32'd100);
    drain(FRAME_PIECES);
    end_test(5, "reset mid-frame");

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== list.f ====
peak_pkg.sv
host_pkg.sv
peak_tagger.sv
sync_fifo_w2n.sv
buf_peak_data.sv
peak_detect_top.sv
tb_clk_gen.sv
tb_peak_detect.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator.
# Pass or fail comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_peak_detect \
  -f list.f -Mdir obj_dir -o sim_peak_detect
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_peak_detect > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
  exit 0
fi
exit 1
